//--- hw/cvt_pkg.sv
package cvt_pkg;

    // Datapath and scratch memory sizes
    localparam int DATA_W    = 16;             // One scratch word
    localparam int ADDR_W    = 6;              // Scratch address bits
    localparam int MEM_DEPTH = 64;             // Scratch words
    localparam int CNT_W     = 7;              // Job length, 1 to 64 words

    // Job direction codes
    localparam logic DT_INT16 = 1'b0;          // INT16 in, BF16 out
    localparam logic DT_BF16  = 1'b1;          // BF16 in, INT16 out

    // BF16 exponent constants
    localparam logic [7:0] BF16_BIAS   = 8'd127;
    // Bias plus 15, largest exponent whose value still fits a 16-bit shift
    localparam logic [7:0] F2I_MAX_EXP = 8'd142;

    // INT16 saturation limits
    localparam logic [15:0] INT16_MAX = 16'h7FFF;
    localparam logic [15:0] INT16_MIN = 16'h8000;

    // Engine datapath
    localparam int RQ_DEPTH   = 4;             // Result queue entries
    // Read grant to converter output, one RAM cycle plus two converter stages
    localparam int PIPE_DEPTH = 3;

endpackage

//--- hw/bf_int_cvt.sv
module bf_int_cvt (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dt,    // DT_INT16 or DT_BF16
    input  logic [cvt_pkg::DATA_W-1:0] in,
    output logic [cvt_pkg::DATA_W-1:0] out    // Two cycles after in
);
    import cvt_pkg::*;

    // Stage one, integer to float
    logic              i2f_sign;
    logic [DATA_W-1:0] i2f_mag;
    logic              i2f_zero;
    logic [3:0]        i2f_lead;              // Leading one position

    // Stage one, float to integer
    logic              f2i_sign;
    logic [7:0]        f2i_exp;
    logic [6:0]        f2i_man;
    logic              f2i_zero;              // Zero or denormal
    logic              f2i_special;           // Exponent all ones
    logic              f2i_nan;
    logic              f2i_inf;
    logic              f2i_under;
    logic              f2i_over;
    logic [7:0]        f2i_rsh_full;
    logic [DATA_W-1:0] f2i_shifted;

    // Stage registers
    logic              dt_r;
    logic              i2f_sign_r;
    logic              i2f_zero_r;
    logic [DATA_W-1:0] i2f_mag_r;
    logic [3:0]        i2f_lead_r;
    logic              f2i_sign_r;
    logic              f2i_zero_r;
    logic              f2i_nan_r;
    logic              f2i_inf_r;
    logic              f2i_over_r;
    logic [DATA_W-1:0] f2i_shifted_r;

    // Stage two results
    logic [3:0]        s2_nsh;
    logic [DATA_W-1:0] s2_norm;
    logic [7:0]        s2_exp;
    logic [DATA_W-1:0] s2_i2f;
    logic              s2_big;
    logic [DATA_W-1:0] s2_f2i;

    assign i2f_sign = in[DATA_W-1];
    assign i2f_mag  = i2f_sign ? (~in + 16'd1) : in;  // -32768 stays 16'h8000
    assign i2f_zero = (in == '0);

    // Priority encoder, highest set bit wins
    always_comb begin
        i2f_lead = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (i2f_mag[i]) begin
                i2f_lead = 4'(i);
            end
        end
    end

    assign f2i_sign    = in[15];
    assign f2i_exp     = in[14:7];
    assign f2i_man     = in[6:0];
    assign f2i_zero    = (f2i_exp == 8'd0);
    assign f2i_special = (f2i_exp == 8'hFF);
    assign f2i_nan     = f2i_special & (f2i_man != 7'd0);
    assign f2i_inf     = f2i_special & (f2i_man == 7'd0);
    assign f2i_under   = ~f2i_zero & (f2i_exp < BF16_BIAS);   // Magnitude below one
    assign f2i_over    = ~f2i_special & (f2i_exp > F2I_MAX_EXP);

    // Hidden one at bit 15, shift right by the missing exponent
    assign f2i_rsh_full = F2I_MAX_EXP - f2i_exp;
    assign f2i_shifted  = {1'b1, f2i_man, 8'd0} >> f2i_rsh_full[3:0];

    // Flags reset, payload fields do not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dt_r       <= DT_INT16;
            i2f_sign_r <= 1'b0;
            i2f_zero_r <= 1'b1;
            f2i_sign_r <= 1'b0;
            f2i_zero_r <= 1'b1;
            f2i_nan_r  <= 1'b0;
            f2i_inf_r  <= 1'b0;
            f2i_over_r <= 1'b0;
        end else begin
            dt_r       <= dt;
            i2f_sign_r <= i2f_sign;
            i2f_zero_r <= i2f_zero;
            f2i_sign_r <= f2i_sign;
            f2i_zero_r <= f2i_zero | f2i_under;       // Both give 0
            f2i_nan_r  <= f2i_nan;
            f2i_inf_r  <= f2i_inf;
            f2i_over_r <= f2i_over;
        end
    end

    always_ff @(posedge clk) begin
        i2f_mag_r     <= i2f_mag;
        i2f_lead_r    <= i2f_lead;
        f2i_shifted_r <= f2i_shifted;
    end

    // Normalize so the leading one lands on bit 15, then pack
    assign s2_nsh  = 4'd15 - i2f_lead_r;
    assign s2_norm = i2f_mag_r << s2_nsh;
    assign s2_exp  = BF16_BIAS + {4'd0, i2f_lead_r};
    assign s2_i2f  = i2f_zero_r ? '0 : {i2f_sign_r, s2_exp, s2_norm[14:8]};  // Truncated mantissa

    // Negative side can reach 32768, positive only 32767
    assign s2_big = f2i_sign_r ? (f2i_shifted_r > INT16_MIN) : (f2i_shifted_r > INT16_MAX);

    always_comb begin
        if (f2i_zero_r || f2i_nan_r) begin
            s2_f2i = '0;
        end else if (f2i_inf_r || f2i_over_r || s2_big) begin
            s2_f2i = f2i_sign_r ? INT16_MIN : INT16_MAX;      // Saturate by sign
        end else if (f2i_sign_r) begin
            s2_f2i = ~f2i_shifted_r + 16'd1;
        end else begin
            s2_f2i = f2i_shifted_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else begin
            out <= (dt_r == DT_BF16) ? s2_f2i : s2_i2f;
        end
    end

endmodule

//--- hw/scratch_ram.sv
module scratch_ram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [cvt_pkg::ADDR_W-1:0] addr,
    input  logic [cvt_pkg::DATA_W-1:0] wdata,
    output logic [cvt_pkg::DATA_W-1:0] rdata
);
    import cvt_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // One access per enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;   // rdata keeps the last read
            end else begin
                rdata <= mem[addr];   // Valid after this edge
            end
        end
    end

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    // Host master
    input  logic                       host_req,
    input  logic                       host_we,
    input  logic [cvt_pkg::ADDR_W-1:0] host_addr,
    input  logic [cvt_pkg::DATA_W-1:0] host_wdata,
    output logic                       host_gnt,
    // Engine master
    input  logic                       eng_req,
    input  logic                       eng_we,
    input  logic [cvt_pkg::ADDR_W-1:0] eng_addr,
    input  logic [cvt_pkg::DATA_W-1:0] eng_wdata,
    output logic                       eng_gnt,
    // RAM port
    output logic                       ram_en,
    output logic                       ram_we,
    output logic [cvt_pkg::ADDR_W-1:0] ram_addr,
    output logic [cvt_pkg::DATA_W-1:0] ram_wdata
);

    logic last_eng;   // Engine won the previous grant

    // Host wins alone, or on a tie when the engine went last
    assign host_gnt = host_req & (~eng_req | last_eng);
    assign eng_gnt  = eng_req & ~host_gnt;

    assign ram_en    = host_gnt | eng_gnt;
    assign ram_we    = eng_gnt ? eng_we : host_we;
    assign ram_addr  = eng_gnt ? eng_addr : host_addr;
    assign ram_wdata = eng_gnt ? eng_wdata : host_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_eng <= 1'b0;
        end else if (ram_en) begin
            last_eng <= eng_gnt;   // Idle cycles keep the old winner
        end
    end

endmodule

//--- hw/host_port.sv
module host_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_strobe,
    input  logic                       rd_strobe,
    input  logic [cvt_pkg::ADDR_W-1:0] addr,
    input  logic [cvt_pkg::DATA_W-1:0] wr_data,
    output logic                       busy,
    output logic [cvt_pkg::DATA_W-1:0] read_data,
    output logic                       read_valid,
    output logic                       req,
    output logic                       we,
    output logic [cvt_pkg::ADDR_W-1:0] req_addr,
    output logic [cvt_pkg::DATA_W-1:0] req_wdata,
    input  logic                       gnt,
    input  logic [cvt_pkg::DATA_W-1:0] ram_rdata
);

    logic accept;    // Strobe taken this cycle
    logic rd_flag;   // RAM read done at the last edge

    assign accept = ~req & (wr_strobe | rd_strobe);
    assign busy   = req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req        <= 1'b0;
            we         <= 1'b0;
            rd_flag    <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            rd_flag    <= req & gnt & ~we;
            read_valid <= rd_flag;              // Pulse together with read_data
            if (req && gnt) begin
                req <= 1'b0;
            end else if (accept) begin
                req <= 1'b1;
                we  <= wr_strobe;               // Write wins if both strobe
            end
        end
    end

    // Held request fields and returned word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr;
            req_wdata <= wr_data;
        end
        if (rd_flag) begin
            read_data <= ram_rdata;
        end
    end

endmodule

//--- hw/cvt_engine.sv
module cvt_engine (
    input  logic                       clk,
    input  logic                       rst_n,
    // Job interface
    input  logic                       start,
    input  logic [cvt_pkg::ADDR_W-1:0] src_base,
    input  logic [cvt_pkg::ADDR_W-1:0] dst_base,
    input  logic [cvt_pkg::CNT_W-1:0]  count,
    input  logic                       dt,
    output logic                       engine_busy,
    output logic                       done,
    // Arbiter side
    output logic                       req,
    output logic                       we,
    output logic [cvt_pkg::ADDR_W-1:0] req_addr,
    output logic [cvt_pkg::DATA_W-1:0] req_wdata,
    input  logic                       gnt,
    input  logic [cvt_pkg::DATA_W-1:0] ram_rdata,
    // Converter side
    output logic [cvt_pkg::DATA_W-1:0] cvt_in,
    output logic                       cvt_dt,
    input  logic [cvt_pkg::DATA_W-1:0] cvt_out
);
    import cvt_pkg::*;

    logic [ADDR_W-1:0]             rd_addr, wr_addr;
    logic [CNT_W-1:0]              rd_left, wr_left;     // Words still to read / write
    logic [PIPE_DEPTH-1:0]         vld;                  // Bit 0 RAM out, top bit cvt_out
    logic [1:0]                    inflight;
    logic [DATA_W-1:0]             rq_mem [RQ_DEPTH];
    logic [$clog2(RQ_DEPTH)-1:0]   rq_head, rq_tail;
    logic [$clog2(RQ_DEPTH):0]     rq_cnt;
    logic [3:0]                    occ;                  // Queued plus in flight
    logic                          want_wr, want_rd;
    logic                          rd_hold;              // Read asked, not yet granted
    logic                          is_rd;
    logic                          rd_gnt, wr_gnt;
    logic                          push;

    assign inflight = 2'($countones(vld));
    assign occ      = 4'(rq_cnt) + 4'(inflight);

    assign want_wr = (rq_cnt != '0);
    assign want_rd = (rd_left != '0) && (occ < 4'(RQ_DEPTH));   // Credit check

    // A pending read keeps its slot, otherwise writes go first
    assign is_rd     = rd_hold | (~want_wr & want_rd);
    assign req       = engine_busy & (want_wr | is_rd);
    assign we        = ~is_rd;
    assign req_addr  = is_rd ? rd_addr : wr_addr;
    assign req_wdata = rq_mem[rq_head];

    assign rd_gnt = gnt & is_rd;
    assign wr_gnt = gnt & ~is_rd;
    assign push   = vld[PIPE_DEPTH-1];
    assign cvt_in = ram_rdata;                            // Fed every cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            engine_busy <= 1'b0;
            done        <= 1'b0;
            cvt_dt      <= DT_INT16;
            rd_addr     <= '0;
            wr_addr     <= '0;
            rd_left     <= '0;
            wr_left     <= '0;
            vld         <= '0;
            rd_hold     <= 1'b0;
            rq_head     <= '0;
            rq_tail     <= '0;
            rq_cnt      <= '0;
        end else begin
            done    <= 1'b0;
            vld     <= {vld[PIPE_DEPTH-2:0], rd_gnt};
            rd_hold <= req & is_rd & ~gnt;
            if (push) begin
                rq_tail <= rq_tail + 1'b1;
            end
            if (wr_gnt) begin
                rq_head <= rq_head + 1'b1;      // Head word written this edge
            end
            if (push && !wr_gnt) begin
                rq_cnt <= rq_cnt + 1'b1;
            end else if (wr_gnt && !push) begin
                rq_cnt <= rq_cnt - 1'b1;
            end
            if (start && !engine_busy && count != '0) begin
                engine_busy <= 1'b1;            // Latch the job
                cvt_dt      <= dt;
                rd_addr     <= src_base;
                wr_addr     <= dst_base;
                rd_left     <= count;
                wr_left     <= count;
            end else begin
                if (rd_gnt) begin
                    rd_addr <= rd_addr + 1'b1;
                    rd_left <= rd_left - 1'b1;
                end
                if (wr_gnt) begin
                    wr_addr <= wr_addr + 1'b1;
                    wr_left <= wr_left - 1'b1;
                    if (wr_left == CNT_W'(1)) begin
                        done        <= 1'b1;    // Last result in RAM
                        engine_busy <= 1'b0;
                    end
                end
            end
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            rq_mem[rq_tail] <= cvt_out;
        end
    end

endmodule

//--- hw/cvt_top.sv
module cvt_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Host access
    input  logic                       wr_strobe,
    input  logic                       rd_strobe,
    input  logic [cvt_pkg::ADDR_W-1:0] addr,
    input  logic [cvt_pkg::DATA_W-1:0] wr_data,
    output logic                       busy,
    output logic [cvt_pkg::DATA_W-1:0] read_data,
    output logic                       read_valid,
    // Job control
    input  logic                       start,
    input  logic [cvt_pkg::ADDR_W-1:0] src_base,
    input  logic [cvt_pkg::ADDR_W-1:0] dst_base,
    input  logic [cvt_pkg::CNT_W-1:0]  count,
    input  logic                       dt,
    output logic                       engine_busy,
    output logic                       done
);
    import cvt_pkg::*;

    // Host master
    logic              host_req, host_we, host_gnt;
    logic [ADDR_W-1:0] host_addr;
    logic [DATA_W-1:0] host_wdata;
    // Engine master
    logic              eng_req, eng_we, eng_gnt;
    logic [ADDR_W-1:0] eng_addr;
    logic [DATA_W-1:0] eng_wdata;
    // RAM port, read data goes to both masters
    logic              ram_en, ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata, ram_rdata;
    // Converter
    logic [DATA_W-1:0] cvt_in, cvt_out;
    logic              cvt_dt;

    host_port u_host_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_strobe  (wr_strobe),
        .rd_strobe  (rd_strobe),
        .addr       (addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .read_data  (read_data),
        .read_valid (read_valid),
        .req        (host_req),
        .we         (host_we),
        .req_addr   (host_addr),
        .req_wdata  (host_wdata),
        .gnt        (host_gnt),
        .ram_rdata  (ram_rdata)
    );

    cvt_engine u_cvt_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .src_base    (src_base),
        .dst_base    (dst_base),
        .count       (count),
        .dt          (dt),
        .engine_busy (engine_busy),
        .done        (done),
        .req         (eng_req),
        .we          (eng_we),
        .req_addr    (eng_addr),
        .req_wdata   (eng_wdata),
        .gnt         (eng_gnt),
        .ram_rdata   (ram_rdata),
        .cvt_in      (cvt_in),
        .cvt_dt      (cvt_dt),
        .cvt_out     (cvt_out)
    );

    mem_arbiter u_mem_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .eng_req    (eng_req),
        .eng_we     (eng_we),
        .eng_addr   (eng_addr),
        .eng_wdata  (eng_wdata),
        .eng_gnt    (eng_gnt),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    scratch_ram u_scratch_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    bf_int_cvt u_bf_int_cvt (
        .clk   (clk),
        .rst_n (rst_n),
        .dt    (cvt_dt),
        .in    (cvt_in),
        .out   (cvt_out)
    );

endmodule

//--- bench/cvt_ref.svh
`ifndef CVT_REF_SVH
`define CVT_REF_SVH

// INT16 to BF16, mantissa bits below the leading one are truncated
function automatic logic [15:0] int16_to_bf16(input logic [15:0] x);
    logic sgn;
    int   mag;
    int   p;
    int   frac;
    sgn = x[15];
    mag = sgn ? 65536 - int'(x) : int'(x);   // -32768 gives 32768
    if (mag == 0) begin
        return 16'h0000;
    end
    p = 0;
    while ((mag >> (p + 1)) != 0) begin
        p++;                                   // Position of the leading one
    end
    frac = ((mag - (1 << p)) * 128) >> p;      // Seven fraction bits
    return {sgn, 8'(127 + p), 7'(frac)};
endfunction

// BF16 to INT16, truncated toward zero and saturated
function automatic logic [15:0] bf16_to_int16(input logic [15:0] x);
    logic sgn;
    int   e;
    int   val;
    sgn = x[15];
    e   = int'(x[14:7]);
    if (e == 255 && x[6:0] != 7'd0) begin
        return 16'h0000;                       // NaN
    end
    if (e == 255 || e > 127 + 15) begin
        return sgn ? 16'h8000 : 16'h7FFF;      // Infinity or too large
    end
    if (e < 127) begin
        return 16'h0000;                       // Zero, denormal, below one
    end
    val = ((128 + int'(x[6:0])) << (e - 127)) >> 7;
    if (sgn) begin
        if (val >= 32768) begin
            return 16'h8000;
        end
        return 16'(-val);
    end
    if (val > 32767) begin
        return 16'h7FFF;
    end
    return 16'(val);
endfunction

`endif

//--- bench/cvt_tb.sv
module cvt_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cvt_pkg::*;

    `include "cvt_ref.svh"

    localparam int SEED            = 60504;
    localparam int JOB_WORDS       = 16 + 20 + 40 + 64;       // Words over all jobs
    localparam int WATCHDOG_CYCLES = 200 * JOB_WORDS + 4000;  // Margin for host traffic

    logic              clk;
    logic              rst_n;
    logic              wr_strobe, rd_strobe;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic              busy;
    logic [DATA_W-1:0] read_data;
    logic              read_valid;
    logic              start;
    logic [ADDR_W-1:0] src_base, dst_base;
    logic [CNT_W-1:0]  count;
    logic              dt;
    logic              engine_busy;
    logic              done;

    int                done_seen = 0;
    logic [DATA_W-1:0] stim [MEM_DEPTH];    // Source words of the current job

    cvt_top u_cvt_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_strobe   (wr_strobe),
        .rd_strobe   (rd_strobe),
        .addr        (addr),
        .wr_data     (wr_data),
        .busy        (busy),
        .read_data   (read_data),
        .read_valid  (read_valid),
        .start       (start),
        .src_base    (src_base),
        .dst_base    (dst_base),
        .count       (count),
        .dt          (dt),
        .engine_busy (engine_busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    always @(negedge clk) begin
        if (done) begin
            done_seen++;                    // Every done pulse
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Stopping at first error");
        end
    endtask

    function automatic logic [15:0] expected_word(input logic d, input logic [15:0] x);
        return (d == DT_BF16) ? bf16_to_int16(x) : int16_to_bf16(x);
    endfunction

    task automatic wait_host_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        wait_host_idle();
        @(posedge clk);
        wr_strobe <= 1'b1;
        addr      <= a;
        wr_data   <= d;
        @(posedge clk);
        wr_strobe <= 1'b0;                  // One-cycle strobe
    endtask

    // Edges are counted from the edge that drives the strobe
    task automatic host_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d,
                             output int edges);
        wait_host_idle();
        @(posedge clk);
        rd_strobe <= 1'b1;
        addr      <= a;
        @(posedge clk);
        rd_strobe <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (!read_valid) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        d = read_data;                      // Sampled mid-cycle
    endtask

    task automatic pulse_start(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                               input logic [CNT_W-1:0] n, input logic d);
        @(posedge clk);
        start    <= 1'b1;
        src_base <= src;
        dst_base <= dst;
        count    <= n;
        dt       <= d;
        @(posedge clk);
        start    <= 1'b0;
    endtask

    task automatic start_job(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                             input logic [CNT_W-1:0] n, input logic d);
        @(negedge clk);
        while (engine_busy) @(negedge clk);
        pulse_start(src, dst, n, d);
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) @(negedge clk);
    endtask

    task automatic load_words(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            host_write(ADDR_W'(base + i), stim[i]);
        end
    endtask

    // Reads the destination back and compares with the reference
    task automatic verify_job(input int base, input int n, input logic d);
        logic [DATA_W-1:0] got;
        int                edges;
        for (int i = 0; i < n; i++) begin
            host_read(ADDR_W'(base + i), got, edges);
            check_eq(got, expected_word(d, stim[i]), $sformatf("result word %0d", i));
        end
    endtask

    task automatic test_host_access();
        logic [DATA_W-1:0] got;
        int                edges;
        check_eq({15'd0, busy}, 16'd0, "busy after reset");
        check_eq({15'd0, read_valid}, 16'd0, "read_valid after reset");
        check_eq({15'd0, engine_busy}, 16'd0, "engine_busy after reset");
        check_eq({15'd0, done}, 16'd0, "done after reset");
        host_write(6'd50, 16'hA5C3);
        host_read(6'd50, got, edges);
        check_eq(got, 16'hA5C3, "host read back");
        check_eq(16'(edges), 16'd3, "read latency in edges");
    endtask

    task automatic test_int_to_bf();
        stim[0] = 16'h0000;
        stim[1] = 16'h0001;
        stim[2] = 16'hFFFF;                 // -1
        stim[3] = 16'h7FFF;
        stim[4] = 16'h8000;
        stim[5] = 16'd2;
        stim[6] = 16'd255;
        stim[7] = 16'd256;
        stim[8] = 16'hFF7F;                 // -129
        stim[9] = 16'd1000;
        for (int i = 10; i < 16; i++) begin
            stim[i] = 16'($urandom);
        end
        load_words(0, 16);
        start_job(6'd0, 6'd16, 7'd16, DT_INT16);
        wait_done();
        verify_job(16, 16, DT_INT16);
    endtask

    task automatic test_bf_to_int();
        stim[0]  = 16'h7F80;                // +Inf
        stim[1]  = 16'hFF80;                // -Inf
        stim[2]  = 16'h7FC1;                // NaN
        stim[3]  = 16'h0000;
        stim[4]  = 16'h8000;                // -0
        stim[5]  = 16'h0001;                // Denormal
        stim[6]  = 16'h3F00;                // 0.5
        stim[7]  = 16'h46FF;                // 32640, just below 32768
        stim[8]  = 16'h4700;                // 32768 saturates
        stim[9]  = 16'hC700;                // -32768 fits
        stim[10] = 16'h4F00;                // Exponent too large
        stim[11] = 16'hBFC0;                // -1.5
        for (int i = 12; i < 20; i++) begin
            stim[i] = {1'($urandom), 8'(120 + $urandom_range(30)), 7'($urandom)};
        end
        load_words(32, 20);
        start_job(6'd32, 6'd0, 7'd20, DT_BF16);
        wait_done();
        verify_job(0, 20, DT_BF16);
    endtask

    task automatic test_concurrent_host();
        int base_done;
        for (int i = 0; i < 40; i++) begin
            stim[i] = 16'($urandom);
        end
        load_words(0, 40);
        base_done = done_seen;
        start_job(6'd0, 6'd0, 7'd40, DT_INT16);
        fork
            wait_done();
            begin
                logic [DATA_W-1:0] got;
                int                edges;
                for (int a = 44; a < 64; a++) begin
                    host_write(ADDR_W'(a), 16'(a * 1021 + 7));  // Address pattern
                end
                for (int a = 44; a < 64; a++) begin
                    host_read(ADDR_W'(a), got, edges);
                    check_eq(got, 16'(a * 1021 + 7), $sformatf("host word %0d", a));
                end
            end
        join
        repeat (10) @(negedge clk);
        check_eq(16'(done_seen - base_done), 16'd1, "done pulses for one job");
        verify_job(0, 40, DT_INT16);
    endtask

    task automatic test_in_place();
        int base_done;
        for (int i = 0; i < 64; i++) begin
            stim[i] = 16'($urandom);
        end
        load_words(0, 64);
        base_done = done_seen;
        start_job(6'd0, 6'd0, 7'd64, DT_INT16);
        repeat (10) @(negedge clk);
        check_eq({15'd0, engine_busy}, 16'd1, "engine busy before second start");
        pulse_start(6'd0, 6'd0, 7'd64, DT_BF16);   // Must be ignored
        wait_done();
        repeat (20) @(negedge clk);
        check_eq({15'd0, engine_busy}, 16'd0, "engine idle after ignored start");
        check_eq(16'(done_seen - base_done), 16'd1, "done pulses with ignored start");
        verify_job(0, 64, DT_INT16);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        wr_strobe = 1'b0;
        rd_strobe = 1'b0;
        addr      = '0;
        wr_data   = '0;
        start     = 1'b0;
        src_base  = '0;
        dst_base  = '0;
        count     = '0;
        dt        = DT_INT16;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_host_access();
        test_int_to_bf();
        test_bf_to_int();
        test_concurrent_host();
        test_in_place();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+bench
hw/cvt_pkg.sv
hw/bf_int_cvt.sv
hw/scratch_ram.sv
hw/mem_arbiter.sv
hw/host_port.sv
hw/cvt_engine.sv
hw/cvt_top.sv
bench/cvt_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module cvt_tb -f vlog.f
	./obj_dir/Vcvt_tb | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
